/* common/sbit_emu_pkg.sv */
// ------------------------------------------------
// shared widths and types for the s-bit emulator
// ------------------------------------------------

package sbit_emu_pkg;

  // geometry of the emulated front end
  localparam int n_vfats        = 8;   // vfats on the trigger path
  localparam int sbits_per_vfat = 8;   // s-bits per vfat per crossing
  localparam int sbit_w         = n_vfats * sbits_per_vfat;

  // delay line, modelled on a 64 deep addressable shift register
  localparam int dly_depth = 64;
  localparam int dly_sel_w = $clog2(dly_depth);

  // train of 8 crossings: even, odd, then six idle
  localparam int phase_w = 3;

  // slow-control request word
  localparam int req_data_w = 32;

  typedef logic [dly_sel_w-1:0] dly_sel_t;   // tap select
  typedef logic [phase_w-1:0]   phase_t;     // position within the train

  // one vfat worth of s-bits
  typedef logic [sbits_per_vfat-1:0] vfat_sbits_t;

  // all s-bits of one crossing
  // vfat 0 in the low byte, vfat 7 in the high byte
  typedef vfat_sbits_t [n_vfats-1:0] sbit_frame_t;

  // start of train, one bit per vfat
  typedef logic [n_vfats-1:0] sot_frame_t;

  // request toward the link transmitter
  // address and write flag are fixed and not carried here
  typedef struct packed {
    logic                  valid;   // request present this cycle
    logic [req_data_w-1:0] data;    // payload, toggles per accepted request
  } req_t;

  // request fsm states
  typedef enum logic [1:0] {
    st_startup = 2'd0,   // waiting for the startup counter
    st_send    = 2'd1,   // valid asserted
    st_holdoff = 2'd2    // backing off after busy
  } fsm_state_t;

endpackage

/* hdl/bx_timer.sv */
`timescale 1ns/100ps

// bunch crossing timing: startup wait, bc0 marker, train phase
module bx_timer #(
  parameter int STARTUP_CYCLES = 600,  // edges until startup_done
  parameter int BC0_PERIOD     = 32    // crossings between bc0 markers
) (
  input  logic                 clk40,
  input  logic                 rst_n_i,
  output logic                 startup_done_o,  // sticky once set
  output logic                 bc0_o,           // one cycle pulse
  output sbit_emu_pkg::phase_t phase_o          // n mod 8 after edge n
);

  localparam int startup_w = $clog2(STARTUP_CYCLES + 1);
  localparam int bc0_w     = $clog2(BC0_PERIOD);

  logic [startup_w-1:0] startup_cnt;
  logic [bc0_w-1:0]     bc0_cnt;

  // ------------------------------------------------
  // startup wait
  // ------------------------------------------------
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      startup_cnt    <= '0;
      startup_done_o <= 1'b0;
    end else if (!startup_done_o) begin   // counter freezes once done
      if (startup_cnt == startup_w'(STARTUP_CYCLES - 1))
        startup_done_o <= 1'b1;           // high after edge STARTUP_CYCLES
      else
        startup_cnt <= startup_cnt + 1'b1;
    end
  end

  // ------------------------------------------------
  // bc0 period and train phase
  // ------------------------------------------------
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bc0_cnt <= '0;
      bc0_o   <= 1'b0;
      phase_o <= '0;
    end else begin
      phase_o <= phase_o + 1'b1;          // free running, wraps at 8
      bc0_o   <= (bc0_cnt == bc0_w'(BC0_PERIOD - 1));  // registered marker
      if (bc0_cnt == bc0_w'(BC0_PERIOD - 1))
        bc0_cnt <= '0;                    // wrap
      else
        bc0_cnt <= bc0_cnt + 1'b1;
    end
  end

  // marker must be a single crossing wide
  a_bc0_single : assert property (
    @(posedge clk40) disable iff (!rst_n_i) bc0_o |=> !bc0_o
  );

endmodule

/* hdl/request_fsm.sv */
`timescale 1ns/100ps

// slow-control request generator
// waits out startup, toggles data per request, backs off after busy
module request_fsm #(
  parameter int                                  HOLDOFF_CYCLES = 7,
  parameter logic [sbit_emu_pkg::req_data_w-1:0] REQ_SEED       = 32'haaaa_aaaa
) (
  input  logic               clk40,
  input  logic               rst_n_i,
  input  logic               startup_done_i,
  input  logic               busy_i,    // level from link tx
  output sbit_emu_pkg::req_t req_o
);

  import sbit_emu_pkg::*;

  localparam int hold_w = $clog2(HOLDOFF_CYCLES + 1);

  fsm_state_t            state;
  logic [hold_w-1:0]     hold_cnt;   // low-busy edges still to wait, minus one
  logic [req_data_w-1:0] data_q;
  logic                  valid;
  logic                  busy_hit;   // busy counts once startup is over

  assign valid    = (state == st_send);   // moore output
  assign busy_hit = busy_i && ((state != st_startup) || startup_done_i);

  // ------------------------------------------------
  // state register and holdoff counter
  // ------------------------------------------------
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state    <= st_startup;
      hold_cnt <= '0;
    end else if (busy_hit) begin
      state    <= st_holdoff;                     // enter or restart holdoff
      hold_cnt <= hold_w'(HOLDOFF_CYCLES - 1);
    end else begin
      unique case (state)
        st_startup: if (startup_done_i) state <= st_send;
        st_send:    state <= st_send;             // stays until busy
        st_holdoff: begin
          if (hold_cnt == '0)
            state <= st_send;                     // HOLDOFF_CYCLES quiet edges seen
          else
            hold_cnt <= hold_cnt - 1'b1;
        end
        default:    state <= st_startup;
      endcase
    end
  end

  // data toggles after each cycle with valid high, frozen otherwise
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i)
      data_q <= REQ_SEED;
    else if (valid)
      data_q <= ~data_q;
  end

  assign req_o.valid = valid;
  assign req_o.data  = data_q;

  // busy seen at an edge blocks valid in the following cycle
  a_busy_blocks : assert property (
    @(posedge clk40) disable iff (!rst_n_i) busy_i |=> !req_o.valid
  );

  // no request value is skipped while valid is low
  a_data_hold : assert property (
    @(posedge clk40) disable iff (!rst_n_i) !$stable(req_o.data) |-> $past(req_o.valid)
  );

endmodule

/* hdl/pattern_gen.sv */
`timescale 1ns/100ps

// s-bit and sot frame source
// train of 8 crossings: even pattern, odd pattern, six idle
module pattern_gen #(
  parameter sbit_emu_pkg::sbit_frame_t PAT_EVEN = 64'h00fe,
  parameter sbit_emu_pkg::sbit_frame_t PAT_ODD  = 64'h0001
) (
  input  logic                      clk40,
  input  logic                      rst_n_i,
  input  sbit_emu_pkg::phase_t      phase_i,
  output sbit_emu_pkg::sbit_frame_t sbits_o,   // one cycle behind phase_i
  output sbit_emu_pkg::sot_frame_t  sot_o
);

  import sbit_emu_pkg::*;

  localparam phase_t even_phase = phase_t'(0);
  localparam phase_t odd_phase  = phase_t'(1);

  logic sot_now;   // first crossing of the train

  assign sot_now = (phase_i == even_phase);

  // ------------------------------------------------
  // frame register
  // ------------------------------------------------
  // cleared in reset so the delay lines start from an idle history
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sbits_o <= '0;
      sot_o   <= '0;
    end else begin
      unique case (phase_i)
        even_phase: sbits_o <= PAT_EVEN;   // checks the even encoder
        odd_phase:  sbits_o <= PAT_ODD;    // then the odd one
        default:    sbits_o <= '0;         // idle, keeps latency easy to read
      endcase
      sot_o <= {n_vfats{sot_now}};         // every vfat marks the same crossing
    end
  end

endmodule

/* hdl/tap_delay_line.sv */
`timescale 1ns/100ps

// addressable shift register with a combinational tap
// output polarity is flipped per bit by a fixed mask
module tap_delay_line #(
  parameter type      payload_t = logic [7:0],
  parameter payload_t INVERT    = '0,   // bits set here come out inverted
  parameter int       DEPTH     = 64
) (
  input  logic                   clk40,
  input  logic                   rst_n_i,
  input  sbit_emu_pkg::dly_sel_t sel_i,    // may change in any cycle
  input  payload_t               data_i,
  output payload_t               data_o    // latency is sel_i + 1
);

  payload_t taps [DEPTH];   // taps[0] is the newest entry

  // ------------------------------------------------
  // shift chain
  // ------------------------------------------------
  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= '0;            // empty history after reset
      end
    end else begin
      taps[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];     // one entry per crossing
      end
    end
  end

  // tap mux then polarity mask
  assign data_o = taps[sel_i] ^ INVERT;

  // select must address an existing tap
  a_sel_range : assert property (
    @(posedge clk40) disable iff (!rst_n_i) int'(sel_i) < DEPTH
  );

endmodule

/* hdl/sbit_emu_top.sv */
`timescale 1ns/100ps

// front-end stimulus emulator for the optohybrid trigger path
module sbit_emu_top #(
  parameter int                        STARTUP_CYCLES = 600,
  parameter int                        BC0_PERIOD     = 32,
  parameter int                        HOLDOFF_CYCLES = 7,
  parameter sbit_emu_pkg::sbit_frame_t PAT_EVEN       = 64'h00fe,
  parameter sbit_emu_pkg::sbit_frame_t PAT_ODD        = 64'h0001,
  parameter sbit_emu_pkg::sbit_frame_t SBIT_INVERT    = 64'h3208_bd2d_e746_6745,
  parameter sbit_emu_pkg::sot_frame_t  SOT_INVERT     = 8'h86,
  parameter logic [sbit_emu_pkg::req_data_w-1:0] REQ_SEED = 32'haaaa_aaaa
) (
  input  logic                      clk40,
  input  logic                      rst_n_i,
  input  sbit_emu_pkg::dly_sel_t    dly_sel_i,   // shared by both lines
  input  logic                      busy_i,      // link tx back-pressure
  output sbit_emu_pkg::sbit_frame_t sbits_o,
  output sbit_emu_pkg::sot_frame_t  sot_o,
  output logic                      bc0_o,
  output sbit_emu_pkg::req_t        req_o
);

  import sbit_emu_pkg::*;

  logic        startup_done;
  phase_t      phase;
  sbit_frame_t sbits_raw;   // before delay and inversion
  sot_frame_t  sot_raw;

  // ------------------------------------------------
  // timing and pattern source
  // ------------------------------------------------
  bx_timer #(
    .STARTUP_CYCLES (STARTUP_CYCLES),
    .BC0_PERIOD     (BC0_PERIOD)
  ) u_bx_timer (
    .clk40          (clk40),
    .rst_n_i        (rst_n_i),
    .startup_done_o (startup_done),
    .bc0_o          (bc0_o),
    .phase_o        (phase)
  );

  pattern_gen #(
    .PAT_EVEN (PAT_EVEN),
    .PAT_ODD  (PAT_ODD)
  ) u_pattern_gen (
    .clk40    (clk40),
    .rst_n_i  (rst_n_i),
    .phase_i  (phase),
    .sbits_o  (sbits_raw),
    .sot_o    (sot_raw)
  );

  // ------------------------------------------------
  // delay lines, same tap for s-bits and sot
  // ------------------------------------------------
  tap_delay_line #(
    .payload_t (sbit_frame_t),
    .INVERT    (SBIT_INVERT),
    .DEPTH     (dly_depth)
  ) u_sbit_dly (
    .clk40     (clk40),
    .rst_n_i   (rst_n_i),
    .sel_i     (dly_sel_i),
    .data_i    (sbits_raw),
    .data_o    (sbits_o)
  );

  tap_delay_line #(
    .payload_t (sot_frame_t),
    .INVERT    (SOT_INVERT),
    .DEPTH     (dly_depth)
  ) u_sot_dly (
    .clk40     (clk40),
    .rst_n_i   (rst_n_i),
    .sel_i     (dly_sel_i),
    .data_i    (sot_raw),
    .data_o    (sot_o)
  );

  // slow-control requests toward the link
  request_fsm #(
    .HOLDOFF_CYCLES (HOLDOFF_CYCLES),
    .REQ_SEED       (REQ_SEED)
  ) u_request_fsm (
    .clk40          (clk40),
    .rst_n_i        (rst_n_i),
    .startup_done_i (startup_done),
    .busy_i         (busy_i),
    .req_o          (req_o)
  );

endmodule

/* verification/sbit_emu_model.svh */
`ifndef SBIT_EMU_MODEL_SVH
`define SBIT_EMU_MODEL_SVH

// ------------------------------------------------
// reference model state
// ------------------------------------------------
int                    m_edge;                  // rising edges since reset release
fsm_state_t            m_state;                 // request fsm as seen from outside
int                    m_quiet;                 // low-busy edges counted in holdoff
logic [req_data_w-1:0] m_data;
sbit_frame_t           m_sbit_hist [dly_depth]; // [0] is the newest line input
sot_frame_t            m_sot_hist  [dly_depth];

// ideal s-bit frame leaving the pattern source after edge k
function automatic sbit_frame_t ideal_sbits(input int k);
  if (k < 1)
    return '0;                    // source register still in reset state
  case ((k - 1) % 8)
    0:       return PAT_EVEN;
    1:       return PAT_ODD;
    default: return '0;           // six idle crossings
  endcase
endfunction

// sot marks the even crossing on every vfat
function automatic sot_frame_t ideal_sot(input int k);
  if (k < 1)
    return '0;
  return (((k - 1) % 8) == 0) ? '1 : '0;
endfunction

task automatic model_reset();
  m_edge  = 0;
  m_state = st_startup;
  m_quiet = 0;
  m_data  = REQ_SEED;
  for (int i = 0; i < dly_depth; i++) begin
    m_sbit_hist[i] = '0;          // delay lines start empty
    m_sot_hist[i]  = '0;
  end
endtask

// one rising edge, busy as sampled at that edge
task automatic model_step(input logic busy);
  logic started;                  // startup done before this edge
  logic counts;                   // busy has an effect this edge
  started = (m_edge >= STARTUP_CYCLES);
  counts  = busy && ((m_state != st_startup) || started);
  if (m_state == st_send)
    m_data = ~m_data;             // one toggle per valid cycle
  if (counts) begin
    m_state = st_holdoff;         // enter or restart the backoff
    m_quiet = 0;
  end else begin
    case (m_state)
      st_startup: if (started) m_state = st_send;
      st_holdoff: begin
        m_quiet++;
        if (m_quiet == HOLDOFF_CYCLES)
          m_state = st_send;
      end
      default: ;
    endcase
  end
  // line takes in the frame the source held before this edge
  for (int i = dly_depth - 1; i > 0; i--) begin
    m_sbit_hist[i] = m_sbit_hist[i-1];
    m_sot_hist[i]  = m_sot_hist[i-1];
  end
  m_sbit_hist[0] = ideal_sbits(m_edge);
  m_sot_hist[0]  = ideal_sot(m_edge);
  m_edge++;
endtask

// ------------------------------------------------
// expected outputs for the current cycle
// ------------------------------------------------
function automatic sbit_frame_t exp_sbits(input dly_sel_t d);
  return m_sbit_hist[d] ^ SBIT_INVERT;
endfunction

function automatic sot_frame_t exp_sot(input dly_sel_t d);
  return m_sot_hist[d] ^ SOT_INVERT;
endfunction

function automatic logic exp_bc0();
  return (m_edge > 0) && ((m_edge % BC0_PERIOD) == 0);
endfunction

function automatic req_t exp_req();
  req_t r;
  r.valid = (m_state == st_send);  // moore, only in send
  r.data  = m_data;
  return r;
endfunction

// ------------------------------------------------
// compare tasks, one per result type
// ------------------------------------------------
task automatic check_frame(input string name, input sbit_frame_t exp, input sbit_frame_t act);
  if (act !== exp) begin
    $display("[ERROR] %0t ns %s: expected %h, actual %h", $time, name, exp, act);
    abort_run("s-bit frame mismatch");
  end
endtask

task automatic check_sot(input string name, input sot_frame_t exp, input sot_frame_t act);
  if (act !== exp) begin
    $display("[ERROR] %0t ns %s: expected %h, actual %h", $time, name, exp, act);
    abort_run("sot frame mismatch");
  end
endtask

task automatic check_req(input string name, input req_t exp, input req_t act);
  if (act !== exp) begin
    $display("[ERROR] %0t ns %s: expected valid=%0b data=%h, actual valid=%0b data=%h",
             $time, name, exp.valid, exp.data, act.valid, act.data);
    abort_run("request mismatch");
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[ERROR] %0t ns %s: expected %b, actual %b", $time, name, exp, act);
    abort_run("single bit mismatch");
  end
endtask

`endif

/* verification/sbit_emu_tb.sv */
`timescale 1ns/100ps

// testbench for the s-bit emulator top level
module sbit_emu_tb;

  import sbit_emu_pkg::*;

  // dut settings, same values as the top level defaults
  localparam int                    STARTUP_CYCLES = 600;
  localparam int                    BC0_PERIOD     = 32;
  localparam int                    HOLDOFF_CYCLES = 7;
  localparam sbit_frame_t           PAT_EVEN       = 64'h00fe;
  localparam sbit_frame_t           PAT_ODD        = 64'h0001;
  localparam sbit_frame_t           SBIT_INVERT    = 64'h3208_bd2d_e746_6745;
  localparam sot_frame_t            SOT_INVERT     = 8'h86;
  localparam logic [req_data_w-1:0] REQ_SEED       = 32'haaaa_aaaa;

  localparam int          CLK_HALF       = 4;     // 8 ns period
  localparam int          RESET_CYCLES   = 3;
  localparam int          RUN_CYCLES     = 3000;  // well past startup
  localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 6;  // 3500
  localparam int unsigned SEED           = 32'h2b65_12a4;

  logic        clk40;
  logic        rst_n_i;
  dly_sel_t    dly_sel_i;
  logic        busy_i;
  sbit_frame_t sbits_o;
  sot_frame_t  sot_o;
  logic        bc0_o;
  req_t        req_o;

  int          cycle_cnt  = 0;   // free running, for the timeout
  int          burst_left = 0;   // busy cycles still to drive

  // first failure ends the run
  task automatic abort_run(input string why);
    $display("TEST RESULT: FAIL");
    $fatal(1, why);
  endtask

  `include "sbit_emu_model.svh"

  sbit_emu_top #(
    .STARTUP_CYCLES (STARTUP_CYCLES),
    .BC0_PERIOD     (BC0_PERIOD),
    .HOLDOFF_CYCLES (HOLDOFF_CYCLES),
    .PAT_EVEN       (PAT_EVEN),
    .PAT_ODD        (PAT_ODD),
    .SBIT_INVERT    (SBIT_INVERT),
    .SOT_INVERT     (SOT_INVERT),
    .REQ_SEED       (REQ_SEED)
  ) dut_i (
    .clk40     (clk40),
    .rst_n_i   (rst_n_i),
    .dly_sel_i (dly_sel_i),
    .busy_i    (busy_i),
    .sbits_o   (sbits_o),
    .sot_o     (sot_o),
    .bc0_o     (bc0_o),
    .req_o     (req_o)
  );

  always #CLK_HALF clk40 = ~clk40;

  // ------------------------------------------------
  // timeout
  // ------------------------------------------------
  always @(posedge clk40) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d clock cycles", cycle_cnt);
      abort_run("run timed out");
    end
  end

  // new random tap each cycle, busy in short bursts
  task automatic drive_inputs();
    dly_sel_i = dly_sel_t'($urandom_range(dly_depth - 1));
    if (burst_left > 0) begin
      busy_i = 1'b1;
      burst_left--;
    end else if ($urandom_range(15) == 0) begin
      busy_i     = 1'b1;                  // burst start
      burst_left = $urandom_range(3);     // up to three more cycles
    end else begin
      busy_i = 1'b0;
    end
  endtask

  task automatic check_outputs();
    logic sot_set;    // all sot bits set after inversion is undone
    logic even_seen;  // model line holds the even frame at this tap
    check_frame("sbits_o", exp_sbits(dly_sel_i), sbits_o);
    check_sot("sot_o", exp_sot(dly_sel_i), sot_o);
    check_bit("bc0_o", exp_bc0(), bc0_o);
    check_req("req_o", exp_req(), req_o);
    // sot and the even frame leave the lines together
    sot_set   = ((sot_o ^ SOT_INVERT) == '1);
    even_seen = (m_sbit_hist[dly_sel_i] == PAT_EVEN);
    check_bit("sot_o with even frame", even_seen, sot_set);
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    void'($urandom(SEED));        // seeds the generator once
    clk40     = 1'b0;
    rst_n_i   = 1'b0;
    dly_sel_i = '0;
    busy_i    = 1'b0;
    model_reset();

    repeat (RESET_CYCLES) @(posedge clk40);
    @(negedge clk40);
    rst_n_i = 1'b1;

    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      drive_inputs();               // on the falling edge
      #(CLK_HALF - 1);              // outputs settled, edge not yet reached
      check_outputs();
      @(posedge clk40);
      model_step(busy_i);
      @(negedge clk40);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+verification
common/sbit_emu_pkg.sv
hdl/bx_timer.sv
hdl/request_fsm.sv
hdl/pattern_gen.sv
hdl/tap_delay_line.sv
hdl/sbit_emu_top.sv
verification/sbit_emu_tb.sv
